//--- rtl/cpu_pkg.sv
package cpu_pkg;

  // ------------------------------------------------------------------
  // Data and control word types
  // ------------------------------------------------------------------

  // One data byte: registers, immediate, ALU operands and result
  typedef logic [7:0] byte_t;

  // ALU operation code
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SR  = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  // Codes 5..7 are illegal

  // Register select, shared by source and destination fields
  typedef logic [1:0] reg_sel_t;

  localparam reg_sel_t SEL_A        = 2'd0;
  localparam reg_sel_t SEL_X        = 2'd1;
  localparam reg_sel_t SEL_Y        = 2'd2;
  // Immediate as a source, no write-back as a destination
  localparam reg_sel_t SEL_IMM_NONE = 2'd3;

  // Carry-in source for ADD and SR
  typedef logic carry_mode_t;

  localparam carry_mode_t CARRY_FLAG = 1'b0;
  localparam carry_mode_t CARRY_ZERO = 1'b1;

  // Status flags, bit positions below
  typedef logic [3:0] flags_t;

  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_V = 2;
  localparam int FLAG_N = 3;

  // Sequencer states
  typedef enum logic [1:0] {ST_IDLE, ST_OPERAND, ST_EXECUTE} seq_state_t;

endpackage

//--- rtl/alu.sv
module cpu_alu import cpu_pkg::*; (
  input  alu_op_t op,
  input  byte_t   a,
  input  byte_t   b,
  input  logic    carry_in,
  output byte_t   y,
  output logic    carry_out,
  output logic    overflow
);

  // ------------------------------------------------------------------
  // Adder
  // ------------------------------------------------------------------

  // Ninth bit holds the carry
  logic [8:0] sum;

  assign sum = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};

  // ------------------------------------------------------------------
  // Operation mux
  // ------------------------------------------------------------------

  always_comb begin
    // Logic ops leave carry and overflow low
    y         = '0;
    carry_out = 1'b0;
    overflow  = 1'b0;
    case (op)
      ALU_ADD: begin
        y         = sum[7:0];
        carry_out = sum[8];
        // Same operand signs, result sign flipped
        overflow  = ~(a[7] ^ b[7]) & (a[7] ^ sum[7]);
      end
      ALU_SR: begin
        // Carry enters at the top, bit 0 falls out
        y         = {carry_in, a[7:1]};
        carry_out = a[0];
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      default: begin
        // Illegal code, result forced to zero
        y = '0;
      end
    endcase
  end

  // Only codes 0..4 may reach the ALU
  always_comb begin
    if (!$isunknown(op)) begin
      assert (op <= ALU_XOR)
        else $error("cpu_alu: illegal operation code %0d", op);
    end
  end

endmodule

//--- rtl/register_file.sv
module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_sel_t rd_a_sel,
  input  reg_sel_t rd_b_sel,
  input  byte_t    imm,
  output byte_t    rd_a,
  output byte_t    rd_b,
  input  logic     wr_en,
  input  reg_sel_t wr_sel,
  input  byte_t    wr_data
);

  // Architectural registers
  byte_t a_q;
  byte_t x_q;
  byte_t y_q;

  // Read mux, select 3 falls back to a port-specific value
  function automatic byte_t read_reg(input reg_sel_t sel, input byte_t fallback);
    byte_t value;
    case (sel)
      SEL_A:   value = a_q;
      SEL_X:   value = x_q;
      SEL_Y:   value = y_q;
      default: value = fallback;
    endcase
    return value;
  endfunction

  // Port a gives A when there is no destination
  assign rd_a = read_reg(rd_a_sel, a_q);
  // Port b gives the immediate
  assign rd_b = read_reg(rd_b_sel, imm);

  // Single write port
  always_ff @(posedge clk) begin
    if (reset) begin
      a_q <= '0;
      x_q <= '0;
      y_q <= '0;
    end else if (wr_en) begin
      case (wr_sel)
        SEL_A:   a_q <= wr_data;
        SEL_X:   x_q <= wr_data;
        SEL_Y:   y_q <= wr_data;
        default: ;  // No destination, write dropped
      endcase
    end
  end

endmodule

//--- rtl/status_register.sv
module status_register import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    update,
  input  alu_op_t op,
  input  byte_t   y,
  input  logic    carry_out,
  input  logic    overflow,
  output flags_t  flags
);

  // ------------------------------------------------------------------
  // Flag update rules
  // ------------------------------------------------------------------
  //   ADD       N Z C V
  //   SR        N Z C
  //   AND/OR/XOR N Z
  // ------------------------------------------------------------------

  logic result_zero;

  assign result_zero = (y == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (update) begin
      // Sign and zero follow every result
      flags[FLAG_N] <= y[7];
      flags[FLAG_Z] <= result_zero;
      case (op)
        ALU_ADD: begin
          flags[FLAG_C] <= carry_out;
          flags[FLAG_V] <= overflow;
        end
        ALU_SR: begin
          // Shift out bit goes to C, V holds
          flags[FLAG_C] <= carry_out;
        end
        default: begin
          // Logic ops keep C and V
        end
      endcase
    end
  end

endmodule

//--- rtl/exec_sequencer.sv
module exec_sequencer import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  alu_op_t     instr_op,
  input  reg_sel_t    instr_src,
  input  reg_sel_t    instr_dst,
  input  carry_mode_t instr_carry,
  input  byte_t       rd_a,
  input  byte_t       rd_b,
  input  logic        c_flag,
  output reg_sel_t    rd_a_sel,
  output reg_sel_t    rd_b_sel,
  output alu_op_t     alu_op,
  output byte_t       alu_a,
  output byte_t       alu_b,
  output logic        carry_in,
  output reg_sel_t    wr_sel,
  output logic        exec_commit,
  output logic        busy,
  output logic        done
);

  seq_state_t  state;
  seq_state_t  state_next;

  // Latched instruction
  alu_op_t     op_q;
  reg_sel_t    src_q;
  reg_sel_t    dst_q;
  carry_mode_t carry_q;

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:    if (instr_valid) state_next = ST_OPERAND;
      ST_OPERAND: state_next = ST_EXECUTE;
      ST_EXECUTE: state_next = ST_IDLE;
      default:    state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      done    <= 1'b0;
      op_q    <= ALU_ADD;
      src_q   <= SEL_A;
      dst_q   <= SEL_IMM_NONE;
      carry_q <= CARRY_ZERO;
    end else begin
      state <= state_next;
      // Done trails the commit by one cycle
      done  <= exec_commit;
      // Accept only when idle
      if (state == ST_IDLE && instr_valid) begin
        op_q    <= instr_op;
        src_q   <= instr_src;
        dst_q   <= instr_dst;
        carry_q <= instr_carry;
      end
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (state == ST_OPERAND) begin
      alu_a <= rd_a;
      alu_b <= rd_b;
    end
  end

  // Accumulator side reads the destination, other side the source
  assign rd_a_sel    = dst_q;
  assign rd_b_sel    = src_q;
  assign alu_op      = op_q;
  assign wr_sel      = dst_q;
  assign carry_in    = (carry_q == CARRY_FLAG) ? c_flag : 1'b0;
  assign exec_commit = (state == ST_EXECUTE);
  assign busy        = (state != ST_IDLE);

  // Instruction fields must be known when the instruction is taken
  assert property (@(posedge clk) disable iff (reset)
    (state == ST_IDLE && instr_valid) |->
      !$isunknown({instr_op, instr_src, instr_dst, instr_carry}))
    else $error("exec_sequencer: unknown instruction field at accept");

endmodule

//--- rtl/exec_unit_top.sv
module exec_unit_top import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  alu_op_t     instr_op,
  input  reg_sel_t    instr_src,
  input  reg_sel_t    instr_dst,
  input  byte_t       instr_imm,
  input  carry_mode_t instr_carry,
  output logic        busy,
  output logic        done,
  output byte_t       result,
  output flags_t      flags
);

  // Sequencer to register file
  reg_sel_t rd_a_sel;
  reg_sel_t rd_b_sel;
  reg_sel_t wr_sel;
  byte_t    rd_a;
  byte_t    rd_b;

  // ALU datapath
  alu_op_t  alu_op;
  byte_t    alu_a;
  byte_t    alu_b;
  byte_t    alu_y;
  logic     carry_in;
  logic     carry_out;
  logic     overflow;

  logic     exec_commit;
  byte_t    imm_q;

  // Immediate held for the operand cycle
  always_ff @(posedge clk) begin
    if (instr_valid && !busy) begin
      imm_q <= instr_imm;
    end
  end

  // Result output loads with the write-back
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (exec_commit) begin
      result <= alu_y;
    end
  end

  // ------------------------------------------------------------------
  // Submodules
  // ------------------------------------------------------------------

  exec_sequencer exec_sequencer_inst (
    .clk(clk), .reset(reset), .instr_valid(instr_valid),
    .instr_op(instr_op), .instr_src(instr_src), .instr_dst(instr_dst),
    .instr_carry(instr_carry), .rd_a(rd_a), .rd_b(rd_b),
    .c_flag(flags[FLAG_C]), .rd_a_sel(rd_a_sel), .rd_b_sel(rd_b_sel),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .carry_in(carry_in),
    .wr_sel(wr_sel), .exec_commit(exec_commit), .busy(busy), .done(done)
  );

  register_file register_file_inst (
    .clk(clk), .reset(reset), .rd_a_sel(rd_a_sel), .rd_b_sel(rd_b_sel),
    .imm(imm_q), .rd_a(rd_a), .rd_b(rd_b), .wr_en(exec_commit),
    .wr_sel(wr_sel), .wr_data(alu_y)
  );

  cpu_alu cpu_alu_inst (
    .op(alu_op), .a(alu_a), .b(alu_b), .carry_in(carry_in),
    .y(alu_y), .carry_out(carry_out), .overflow(overflow)
  );

  status_register status_register_inst (
    .clk(clk), .reset(reset), .update(exec_commit), .op(alu_op),
    .y(alu_y), .carry_out(carry_out), .overflow(overflow), .flags(flags)
  );

  // Host must wait for busy to fall
  assert property (@(posedge clk) disable iff (reset) !(instr_valid && busy))
    else $error("exec_unit_top: instr_valid while busy");

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // Free-running clock, 8 units per period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Reset covers the first 3 rising edges
  // Released on a falling edge, away from the DUT sampling edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- verification/exec_unit_checker.sv
module exec_unit_checker import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        instr_valid,
  input  logic        busy,
  input  logic        done,
  input  byte_t       result,
  input  flags_t      flags,
  input  logic [95:0] exp_name,
  input  byte_t       exp_result,
  input  flags_t      exp_flags,
  output int          tests_done,
  output int          tests_failed
);

  // Expectation of the instruction in flight
  logic [95:0] name_q;
  byte_t       result_q;
  flags_t      flags_q;
  logic        pending;

  // Handshake timing of the instruction in flight
  int          cycles_q;
  logic        busy_low_q;
  logic        timing_ok;
  logic        value_ok;

  // Done is due 3 edges after accept and busy is low by then
  assign timing_ok = (cycles_q == 3) && !busy && !busy_low_q;
  assign value_ok  = (result === result_q) && (flags === flags_q);

  // ------------------------------------------------------------------
  // Capture on accept, compare on done
  // ------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      pending      <= 1'b0;
      cycles_q     <= 0;
      busy_low_q   <= 1'b0;
      tests_done   <= 0;
      tests_failed <= 0;
    end else begin
      // Busy must stay high until the done cycle
      if (pending) begin
        cycles_q <= cycles_q + 1;
        if (!done && !busy) begin
          busy_low_q <= 1'b1;
        end
      end
      // Done seen here belongs to the cycle just ended
      if (done) begin
        if (!pending) begin
          $display("ERROR: done pulse arrived with no instruction in flight");
          tests_failed <= tests_failed + 1;
        end else begin
          if (!value_ok) begin
            $display("FAIL %s: expected result %02h flags %04b, actual result %02h flags %04b",
                     name_q, result_q, flags_q, result, flags);
            tests_failed <= tests_failed + 1;
          end else if (!timing_ok) begin
            $display("FAIL %s: busy or done out of step, expected done after 3 cycles, actual %0d",
                     name_q, cycles_q);
            tests_failed <= tests_failed + 1;
          end else begin
            $display("PASS %s: result %02h flags %04b", name_q, result, flags);
          end
          tests_done <= tests_done + 1;
        end
        pending <= 1'b0;
      end
      // Same rule the DUT uses to take an instruction
      if (instr_valid && !busy) begin
        name_q     <= exp_name;
        result_q   <= exp_result;
        flags_q    <= exp_flags;
        pending    <= 1'b1;
        cycles_q   <= 1;
        busy_low_q <= 1'b0;
      end
    end
  end

endmodule

//--- verification/exec_unit_tb.sv
module exec_unit_tb import cpu_pkg::*; ();

  localparam int NUM_TESTS = 18;
  // 4 cycles per entry, plus reset and drain slack
  localparam int TIMEOUT_CYCLES = 4 * NUM_TESTS + 20;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  alu_op_t     instr_op;
  reg_sel_t    instr_src;
  reg_sel_t    instr_dst;
  byte_t       instr_imm;
  carry_mode_t instr_carry;
  logic        busy;
  logic        done;
  byte_t       result;
  flags_t      flags;

  // Expected values handed to the checker with each instruction
  logic [95:0] exp_name;
  byte_t       exp_result;
  flags_t      exp_flags;
  int          tests_done;
  int          tests_failed;
  int          cycle_count = 0;

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------

  logic [95:0] tbl_name [NUM_TESTS];
  alu_op_t     tbl_op [NUM_TESTS];
  reg_sel_t    tbl_src [NUM_TESTS];
  reg_sel_t    tbl_dst [NUM_TESTS];
  byte_t       tbl_imm [NUM_TESTS];
  carry_mode_t tbl_carry [NUM_TESTS];
  byte_t       tbl_result [NUM_TESTS];
  flags_t      tbl_flags [NUM_TESTS];
  int          n_entries = 0;

  task automatic add_entry(input logic [95:0] name, input alu_op_t op, input reg_sel_t src,
                           input reg_sel_t dst, input byte_t imm, input carry_mode_t carry,
                           input byte_t res, input flags_t flg);
    tbl_name[n_entries]   = name;
    tbl_op[n_entries]     = op;
    tbl_src[n_entries]    = src;
    tbl_dst[n_entries]    = dst;
    tbl_imm[n_entries]    = imm;
    tbl_carry[n_entries]  = carry;
    tbl_result[n_entries] = res;
    tbl_flags[n_entries]  = flg;
    n_entries++;
  endtask

  // One-cycle instr_valid pulse, called on a falling edge
  task automatic issue(input int idx);
    instr_op    = tbl_op[idx];
    instr_src   = tbl_src[idx];
    instr_dst   = tbl_dst[idx];
    instr_imm   = tbl_imm[idx];
    instr_carry = tbl_carry[idx];
    exp_name    = tbl_name[idx];
    exp_result  = tbl_result[idx];
    exp_flags   = tbl_flags[idx];
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  // ------------------------------------------------------------------
  // Clock, DUT and checker
  // ------------------------------------------------------------------

  tb_clock_gen tb_clock_gen_inst (.clk(clk), .reset(reset));

  exec_unit_top exec_unit_top_inst (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr_op(instr_op),
    .instr_src(instr_src), .instr_dst(instr_dst), .instr_imm(instr_imm),
    .instr_carry(instr_carry), .busy(busy), .done(done), .result(result), .flags(flags)
  );

  exec_unit_checker exec_unit_checker_inst (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .busy(busy), .done(done),
    .result(result), .flags(flags), .exp_name(exp_name), .exp_result(exp_result),
    .exp_flags(exp_flags), .tests_done(tests_done), .tests_failed(tests_failed)
  );

  initial begin
    instr_valid = 1'b0;
    instr_op    = ALU_OR;
    instr_src   = SEL_IMM_NONE;
    instr_dst   = SEL_IMM_NONE;
    instr_imm   = '0;
    instr_carry = CARRY_ZERO;
    exp_name    = '0;
    exp_result  = '0;
    exp_flags   = '0;

    // Columns: name, op, src, dst, imm, carry, result, flags as NVZC
    // Loads through OR from zeroed registers, C and V hold
    add_entry("ld_a_zero", ALU_OR, SEL_IMM_NONE, SEL_A, 8'h00, CARRY_ZERO, 8'h00, 4'b0010);
    add_entry("ld_x_80", ALU_OR, SEL_IMM_NONE, SEL_X, 8'h80, CARRY_ZERO, 8'h80, 4'b1000);
    add_entry("ld_y_50", ALU_OR, SEL_IMM_NONE, SEL_Y, 8'h50, CARRY_ZERO, 8'h50, 4'b0000);
    add_entry("ld_a_50", ALU_OR, SEL_IMM_NONE, SEL_A, 8'h50, CARRY_ZERO, 8'h50, 4'b0000);
    // 0x50 + 0x50 overflows into the sign bit
    add_entry("add_ovf", ALU_ADD, SEL_Y, SEL_A, 8'h00, CARRY_ZERO, 8'hA0, 4'b1100);
    add_entry("ld_a_ff", ALU_OR, SEL_IMM_NONE, SEL_A, 8'hFF, CARRY_ZERO, 8'hFF, 4'b1100);
    add_entry("add_carry", ALU_ADD, SEL_IMM_NONE, SEL_A, 8'h01, CARRY_ZERO, 8'h00, 4'b0011);
    // Carry from the previous ADD comes in
    add_entry("adc_in", ALU_ADD, SEL_IMM_NONE, SEL_A, 8'h10, CARRY_FLAG, 8'h11, 4'b0000);
    add_entry("add_xx", ALU_ADD, SEL_X, SEL_X, 8'h00, CARRY_ZERO, 8'h00, 4'b0111);
    // ROR and LSR, V holds from add_xx
    add_entry("ror_y", ALU_SR, SEL_IMM_NONE, SEL_Y, 8'h00, CARRY_FLAG, 8'hA8, 4'b1100);
    add_entry("lsr_a", ALU_SR, SEL_IMM_NONE, SEL_A, 8'h00, CARRY_ZERO, 8'h08, 4'b0101);
    // Logic ops keep C and V
    add_entry("and_ay", ALU_AND, SEL_Y, SEL_A, 8'h00, CARRY_ZERO, 8'h08, 4'b0101);
    add_entry("xor_ay", ALU_XOR, SEL_Y, SEL_A, 8'h00, CARRY_ZERO, 8'hA0, 4'b1101);
    add_entry("xor_yy", ALU_XOR, SEL_Y, SEL_Y, 8'h00, CARRY_ZERO, 8'h00, 4'b0111);
    // No destination, A must keep 0xA0
    add_entry("add_none", ALU_ADD, SEL_IMM_NONE, SEL_IMM_NONE, 8'h01, CARRY_FLAG, 8'hA2,
              4'b1000);
    add_entry("sr_none", ALU_SR, SEL_IMM_NONE, SEL_IMM_NONE, 8'h00, CARRY_FLAG, 8'h50,
              4'b0000);
    add_entry("or_a_keep", ALU_OR, SEL_IMM_NONE, SEL_A, 8'h00, CARRY_ZERO, 8'hA0, 4'b1000);
    add_entry("or_y_zero", ALU_OR, SEL_IMM_NONE, SEL_Y, 8'h00, CARRY_ZERO, 8'h00, 4'b0010);

    @(negedge clk);
    while (reset) @(negedge clk);

    // Each instruction goes in as soon as busy falls
    for (int i = 0; i < n_entries; i++) begin
      while (busy) @(negedge clk);
      issue(i);
    end
    while (tests_done < n_entries) @(negedge clk);

    $display("Tests run: %0d, failed: %0d", tests_done, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: done never arrived, %0d of %0d tests finished in %0d cycles",
               tests_done, n_entries, cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

//--- tb.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/status_register.sv
rtl/exec_sequencer.sv
rtl/exec_unit_top.sv
verification/tb_clock_gen.sv
verification/exec_unit_checker.sv
verification/exec_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= exec_unit_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
